// File: sim/mipsPatterns.txt
# columns: kind (I instruction, D initial data, S expected store), address, word, all hex
# S lines list the stores in program order
I 00000000 20010005  # addi $1,$0,5
I 00000004 2002000C  # addi $2,$0,12
I 00000008 00221820  # add  $3,$1,$2   wb and mem forwarding
I 0000000C AC030000  # sw   $3,0($0)   17
I 00000010 00612022  # sub  $4,$3,$1
I 00000014 AC040004  # sw   $4,4($0)   12
I 00000018 00412824  # and  $5,$2,$1
I 0000001C AC050008  # sw   $5,8($0)   4
I 00000020 00A33025  # or   $6,$5,$3
I 00000024 AC06000C  # sw   $6,12($0)  21
I 00000028 2008FFFD  # addi $8,$0,-3
I 0000002C 0101382A  # slt  $7,$8,$1   signed, 1
I 00000030 AC070010  # sw   $7,16($0)
I 00000034 0028482A  # slt  $9,$1,$8   0
I 00000038 AC090014  # sw   $9,20($0)
I 0000003C 8C0A0040  # lw   $10,64($0)
I 00000040 01465820  # add  $11,$10,$6 load-use stall
I 00000044 AC0B0018  # sw   $11,24($0) 0x115
I 00000048 10210002  # beq  $1,$1,+2   taken
I 0000004C AC01001C  # sw   $1,28($0)  squashed
I 00000050 AC02001C  # sw   $2,28($0)  skipped
I 00000054 200C0007  # addi $12,$0,7
I 00000058 11810001  # beq  $12,$1,+1  not taken, branch stall
I 0000005C AC0C001C  # sw   $12,28($0) 7
I 00000060 0800001B  # j    0x6C
I 00000064 AC010020  # sw   $1,32($0)  skipped
I 00000068 AC020020  # sw   $2,32($0)  skipped
I 0000006C 20000009  # addi $0,$0,9    discarded
I 00000070 AC000020  # sw   $0,32($0)  0
I 00000074 8C0D0044  # lw   $13,68($0)
I 00000078 AC0D0024  # sw   $13,36($0) stall then wb forward
I 0000007C 0800001F  # j    0x7C       halt
D 00000040 00000100
D 00000044 12345678
S 00000000 00000011
S 00000004 0000000C
S 00000008 00000004
S 0000000C 00000015
S 00000010 00000001
S 00000014 00000000
S 00000018 00000115
S 0000001C 00000007
S 00000020 00000000
S 00000024 12345678

// File: all.f
+incdir+design
design/mipsPkg.sv
design/pipeStageReg.sv
design/controlDecoder.sv
design/regFile.sv
design/fetchStage.sv
design/decodeStage.sv
design/executeStage.sv
design/memWbStage.sv
design/hazardUnit.sv
design/mipsCore.sv
sim/mipsCoreTb.sv

// File: sim/mipsCoreTb.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module mipsCoreTb
    import mipsPkg::*;
;

    localparam int memWords      = 256;
    localparam int maxWaitCycles = 400;    // generous for 32 instructions
    localparam int drainCycles   = 20;     // catches stray stores after the last one

    logic  clk;
    logic  rst;
    word_t pcF;
    word_t instr;
    logic  memWrite;
    word_t dataAddr;
    word_t writeData;
    word_t readData;

    word_t imem [memWords];
    word_t dmem [memWords];
    word_t expAddrQ [$];
    word_t expDataQ [$];
    int    storeCount = 0;

    mipsCore mipsCore_inst (
        .clk       (clk),
        .rst       (rst),
        .pcF       (pcF),
        .instr     (instr),
        .memWrite  (memWrite),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .readData  (readData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////
    // word-addressed behavioral memories
    assign instr    = imem[pcF[9:2]];
    assign readData = dmem[dataAddr[9:2]];

    task automatic stopWithFailure();
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic checkStore(word_t expectedAddr, word_t expectedData);
        if (dataAddr !== expectedAddr) begin
            $display("ERROR: dataAddr of store %0d expected 0x%08h got 0x%08h",
                     storeCount, expectedAddr, dataAddr);
            stopWithFailure();
        end else if (writeData !== expectedData) begin
            $display("ERROR: writeData of store %0d expected 0x%08h got 0x%08h",
                     storeCount, expectedData, writeData);
            stopWithFailure();
        end
    endtask

    task automatic checkPc(word_t expected);
        if (pcF !== expected) begin
            $display("ERROR: pcF expected 0x%08h got 0x%08h", expected, pcF);
            stopWithFailure();
        end
    endtask

    task automatic checkLevel(string name, logic actual, logic expected);
        if (actual !== expected) begin
            $display("ERROR: %s expected 0x%0h got 0x%0h", name, expected, actual);
            stopWithFailure();
        end
    endtask

    // eat the rest of the current line
    task automatic skipLine(int fd);
        int c;
        c = $fgetc(fd);
        while (c != "\n" && c != -1) begin
            c = $fgetc(fd);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // pattern lines hold I program words, D initial data and S expected stores
    task automatic loadPatterns();
        int    fd;
        int    c;
        int    n;
        word_t a;
        word_t d;
        fd = $fopen("sim/mipsPatterns.txt", "r");
        if (fd == 0) begin
            $display("could not open the pattern file sim/mipsPatterns.txt");
            stopWithFailure();
        end
        c = $fgetc(fd);
        while (c != -1) begin
            if (c == "#") begin
                skipLine(fd);
            end else if (c == "I" || c == "D" || c == "S") begin
                n = $fscanf(fd, " %h %h", a, d);
                if (n != 2) begin
                    $display("a pattern line could not be read as address and data");
                    stopWithFailure();
                end
                if (c == "I") begin
                    imem[a[9:2]] = d;
                end else if (c == "D") begin
                    dmem[a[9:2]] = d;
                end else begin
                    expAddrQ.push_back(a);
                    expDataQ.push_back(d);
                end
                skipLine(fd);   // trailing comment
            end else if (c != " " && c != "\n" && c != "\r" && c != "\t") begin
                $display("the pattern file holds a line of unknown kind");
                stopWithFailure();
            end
            c = $fgetc(fd);
        end
        $fclose(fd);
    endtask

    // data memory write port and store checking
    always @(posedge clk) begin
        if (memWrite === 1'b1) begin
            if (storeCount >= expAddrQ.size()) begin
                $display("an unexpected store of 0x%08h to address 0x%08h appeared",
                         writeData, dataAddr);
                stopWithFailure();
            end else begin
                checkStore(expAddrQ[storeCount], expDataQ[storeCount]);
                dmem[dataAddr[9:2]] <= writeData;
                storeCount <= storeCount + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // main sequence
    initial begin
        int cycles;
        rst = 1'b1;
        for (int i = 0; i < memWords; i++) begin
            imem[i] = '0;                           // nop
            dmem[i] = 32'hA5A5_0000 ^ (i << 2);     // address-dependent fill
        end
        loadPatterns();
        if (expAddrQ.size() == 0) begin
            $display("the pattern file holds no expected stores");
            stopWithFailure();
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        checkPc(`RESET_PC);     // still in reset
        checkLevel("memWrite", memWrite, 1'b0);
        rst = 1'b0;

        @(negedge clk);
        checkPc(`RESET_PC + 32'd4);     // first fetch advanced
        checkLevel("memWrite", memWrite, 1'b0);

        cycles = 0;
        while (storeCount < expAddrQ.size() && cycles < maxWaitCycles) begin
            @(negedge clk);
            cycles++;
        end
        if (storeCount < expAddrQ.size()) begin
            $display("timeout: only %0d of %0d expected stores arrived within %0d cycles",
                     storeCount, expAddrQ.size(), maxWaitCycles);
            stopWithFailure();
        end else begin
            repeat (drainCycles) @(negedge clk);    // core sits in the halt loop
            $display("ALL TESTS PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: design/mipsCore.sv
`timescale 1ns/100ps
`default_nettype none

module mipsCore
    import mipsPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    output word_t pcF,
    input  word_t instr,
    output logic  memWrite,
    output word_t dataAddr,
    output word_t writeData,
    input  word_t readData
);

    // fetch / decode
    word_t    pcPlus4F;
    ifId_t    ifIdF;
    logic     redirectD;
    word_t    targetD;
    ctrl_t    ctrlD;
    regAddr_t rsD;
    regAddr_t rtD;
    word_t    rd1D;
    word_t    rd2D;
    idEx_t    idExD;
    // execute
    regAddr_t rsE;
    regAddr_t rtE;
    regAddr_t writeRegE;
    logic     regWriteE;
    logic     memToRegE;
    exMem_t   exMemE;
    // memory / writeback
    word_t    memAluOut;
    word_t    resultW;
    exMem_t   exMemView;
    memWb_t   memWbView;
    // hazard controls
    logic     stallF;
    logic     stallD;
    logic     flushE;
    logic     fwdAD;
    logic     fwdBD;
    fwdSel_t  fwdAE;
    fwdSel_t  fwdBE;

    assign ifIdF = '{instr: instr, pcPlus4: pcPlus4F};

    ////////////////////////////////////////////////////////////
    fetchStage fetch (
        .clk      (clk),
        .rst      (rst),
        .stallF   (stallF),
        .redirect (redirectD),
        .target   (targetD),
        .pcF      (pcF),
        .pcPlus4  (pcPlus4F)
    );

    decodeStage decode (
        .clk       (clk),
        .rst       (rst),
        .stallD    (stallD),
        .ifIdIn    (ifIdF),
        .rd1       (rd1D),
        .rd2       (rd2D),
        .memAluOut (memAluOut),
        .fwdAD     (fwdAD),
        .fwdBD     (fwdBD),
        .ctrl      (ctrlD),
        .rs        (rsD),
        .rt        (rtD),
        .redirect  (redirectD),
        .target    (targetD),
        .idEx      (idExD)
    );

    regFile regs (
        .clk (clk),
        .rst (rst),
        .ra1 (rsD),
        .ra2 (rtD),
        .rd1 (rd1D),
        .rd2 (rd2D),
        .we  (memWbView.regWrite),
        .wa  (memWbView.writeReg),
        .wd  (resultW)
    );

    executeStage execute (
        .clk       (clk),
        .rst       (rst),
        .flushE    (flushE),
        .idEx      (idExD),
        .result    (resultW),
        .memAluOut (memAluOut),
        .fwdAE     (fwdAE),
        .fwdBE     (fwdBE),
        .rsE       (rsE),
        .rtE       (rtE),
        .writeRegE (writeRegE),
        .regWriteE (regWriteE),
        .memToRegE (memToRegE),
        .exMem     (exMemE)
    );

    memWbStage memWb (
        .clk       (clk),
        .rst       (rst),
        .exMem     (exMemE),
        .readData  (readData),
        .memWrite  (memWrite),
        .dataAddr  (dataAddr),
        .writeData (writeData),
        .memAluOut (memAluOut),
        .result    (resultW),
        .exMemView (exMemView),
        .memWbView (memWbView)
    );

    hazardUnit hazard (
        .rsD       (rsD),
        .rtD       (rtD),
        .rsE       (rsE),
        .rtE       (rtE),
        .writeRegE (writeRegE),
        .writeRegM (exMemView.writeReg),
        .writeRegW (memWbView.writeReg),
        .branchD   (ctrlD.branch),
        .regWriteE (regWriteE),
        .memToRegE (memToRegE),
        .regWriteM (exMemView.regWrite),
        .memToRegM (exMemView.memToReg),
        .regWriteW (memWbView.regWrite),
        .stallF    (stallF),
        .stallD    (stallD),
        .flushE    (flushE),
        .fwdAD     (fwdAD),
        .fwdBD     (fwdBD),
        .fwdAE     (fwdAE),
        .fwdBE     (fwdBE)
    );

endmodule

`default_nettype wire

// File: design/hazardUnit.sv
`timescale 1ns/100ps
`default_nettype none

module hazardUnit
    import mipsPkg::*;
(
    input  regAddr_t rsD,
    input  regAddr_t rtD,
    input  regAddr_t rsE,
    input  regAddr_t rtE,
    input  regAddr_t writeRegE,
    input  regAddr_t writeRegM,
    input  regAddr_t writeRegW,
    input  logic     branchD,
    input  logic     regWriteE,
    input  logic     memToRegE,
    input  logic     regWriteM,
    input  logic     memToRegM,
    input  logic     regWriteW,
    output logic     stallF,
    output logic     stallD,
    output logic     flushE,
    output logic     fwdAD,
    output logic     fwdBD,
    output fwdSel_t  fwdAE,
    output fwdSel_t  fwdBE
);

    logic loadUseStall;
    logic branchStall;

    // memory stage wins over writeback, r0 never forwarded
    function automatic fwdSel_t pickSource(regAddr_t src, regAddr_t regM, logic weM,
                                           regAddr_t regW, logic weW);
        if (src != '0 && weM && src == regM) begin
            return FWD_MEM;
        end else if (src != '0 && weW && src == regW) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    assign fwdAE = pickSource(rsE, writeRegM, regWriteM, writeRegW, regWriteW);
    assign fwdBE = pickSource(rtE, writeRegM, regWriteM, writeRegW, regWriteW);

    assign fwdAD = (rsD != '0) && regWriteM && (rsD == writeRegM);  // into beq compare
    assign fwdBD = (rtD != '0) && regWriteM && (rtD == writeRegM);

    ////////////////////////////////////////////////////////////
    // stalls
    assign loadUseStall = memToRegE && (rtE == rsD || rtE == rtD);

    assign branchStall = branchD &&
        ((regWriteE && writeRegE != '0 && (writeRegE == rsD || writeRegE == rtD)) ||
         (memToRegM && writeRegM != '0 && (writeRegM == rsD || writeRegM == rtD)));

    assign stallD = loadUseStall || branchStall;
    assign stallF = stallD;
    assign flushE = stallD;     // bubble into execute

endmodule

`default_nettype wire

// File: design/memWbStage.sv
`timescale 1ns/100ps
`default_nettype none

module memWbStage
    import mipsPkg::*;
(
    input  logic   clk,
    input  logic   rst,
    input  exMem_t exMem,
    input  word_t  readData,
    output logic   memWrite,
    output word_t  dataAddr,
    output word_t  writeData,
    output word_t  memAluOut,
    output word_t  result,
    output exMem_t exMemView,       // memory-stage state for hazards
    output memWb_t memWbView
);

    exMem_t exMemQ;
    memWb_t memWbD;
    memWb_t memWbQ;

    pipeStageReg #(.T(exMem_t)) exMemReg (
        .clk   (clk),
        .rst   (rst),
        .en    (1'b1),
        .clear (1'b0),
        .d     (exMem),
        .q     (exMemQ)
    );

    // data memory side
    assign memWrite  = exMemQ.memWrite;
    assign dataAddr  = exMemQ.aluOut;
    assign writeData = exMemQ.writeData;
    assign memAluOut = exMemQ.aluOut;
    assign exMemView = exMemQ;

    assign memWbD = '{
        regWrite: exMemQ.regWrite,
        memToReg: exMemQ.memToReg,
        readData: readData,
        aluOut:   exMemQ.aluOut,
        writeReg: exMemQ.writeReg
    };

    pipeStageReg #(.T(memWb_t)) memWbReg (
        .clk   (clk),
        .rst   (rst),
        .en    (1'b1),
        .clear (1'b0),
        .d     (memWbD),
        .q     (memWbQ)
    );

    assign result    = memWbQ.memToReg ? memWbQ.readData : memWbQ.aluOut;
    assign memWbView = memWbQ;

endmodule

`default_nettype wire

// File: design/executeStage.sv
`timescale 1ns/100ps
`default_nettype none

module executeStage
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     flushE,
    input  idEx_t    idEx,
    input  word_t    result,        // writeback value
    input  word_t    memAluOut,
    input  fwdSel_t  fwdAE,
    input  fwdSel_t  fwdBE,
    output regAddr_t rsE,
    output regAddr_t rtE,
    output regAddr_t writeRegE,
    output logic     regWriteE,
    output logic     memToRegE,
    output exMem_t   exMem
);

    idEx_t idExQ;
    word_t srcA;
    word_t srcB;
    word_t writeDataE;
    word_t aluOut;

    pipeStageReg #(.T(idEx_t)) idExReg (
        .clk   (clk),
        .rst   (rst),
        .en    (1'b1),
        .clear (flushE),        // bubble on stall
        .d     (idEx),
        .q     (idExQ)
    );

    always_comb begin
        case (fwdAE)
            FWD_WB:  srcA = result;
            FWD_MEM: srcA = memAluOut;
            default: srcA = idExQ.rd1;
        endcase
        case (fwdBE)
            FWD_WB:  writeDataE = result;
            FWD_MEM: writeDataE = memAluOut;
            default: writeDataE = idExQ.rd2;
        endcase
    end

    assign srcB = idExQ.aluSrc ? idExQ.signImm : writeDataE;

    ////////////////////////////////////////////////////////////
    // alu
    always_comb begin
        case (idExQ.aluOp)
            ALU_AND: aluOut = srcA & srcB;
            ALU_OR:  aluOut = srcA | srcB;
            ALU_ADD: aluOut = srcA + srcB;
            ALU_SUB: aluOut = srcA - srcB;
            ALU_SLT: aluOut = ($signed(srcA) < $signed(srcB)) ? 32'd1 : 32'd0;
            default: aluOut = '0;
        endcase
    end

    assign rsE       = idExQ.rs;
    assign rtE       = idExQ.rt;
    assign writeRegE = idExQ.regDst ? idExQ.rd : idExQ.rt;
    assign regWriteE = idExQ.regWrite;
    assign memToRegE = idExQ.memToReg;

    assign exMem = '{
        regWrite:  idExQ.regWrite,
        memToReg:  idExQ.memToReg,
        memWrite:  idExQ.memWrite,
        aluOut:    aluOut,
        writeData: writeDataE,
        writeReg:  writeRegE
    };

endmodule

`default_nettype wire

// File: design/decodeStage.sv
`timescale 1ns/100ps
`default_nettype none

module decodeStage
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     stallD,
    input  ifId_t    ifIdIn,
    input  word_t    rd1,
    input  word_t    rd2,
    input  word_t    memAluOut,
    input  logic     fwdAD,
    input  logic     fwdBD,
    output ctrl_t    ctrl,
    output regAddr_t rs,
    output regAddr_t rt,
    output logic     redirect,
    output word_t    target,
    output idEx_t    idEx
);

    ifId_t ifIdQ;
    word_t signImm;
    word_t cmpA;
    word_t cmpB;
    word_t branchTarget;
    word_t jumpTarget;
    logic  equalD;

    // IF/ID, squashed behind a redirect
    pipeStageReg #(.T(ifId_t)) ifIdReg (
        .clk   (clk),
        .rst   (rst),
        .en    (!stallD),
        .clear (redirect),
        .d     (ifIdIn),
        .q     (ifIdQ)
    );

    controlDecoder decoder (
        .instr (ifIdQ.instr),
        .ctrl  (ctrl)
    );

    assign rs      = ifIdQ.instr[25:21];
    assign rt      = ifIdQ.instr[20:16];
    assign signImm = {{16{ifIdQ.instr[15]}}, ifIdQ.instr[15:0]};

    ////////////////////////////////////////////////////////////
    // early branch resolution
    assign cmpA   = fwdAD ? memAluOut : rd1;
    assign cmpB   = fwdBD ? memAluOut : rd2;
    assign equalD = (cmpA == cmpB);

    assign branchTarget = ifIdQ.pcPlus4 + {signImm[29:0], 2'b00};
    assign jumpTarget   = {ifIdQ.pcPlus4[31:28], ifIdQ.instr[25:0], 2'b00};

    // operands may be stale while stalled, so hold off
    assign redirect = !stallD && ((ctrl.branch && equalD) || ctrl.jump);
    assign target   = ctrl.jump ? jumpTarget : branchTarget;

    ////////////////////////////////////////////////////////////
    // ID/EX payload
    assign idEx = '{
        regWrite: ctrl.regWrite,
        memToReg: ctrl.memToReg,
        memWrite: ctrl.memWrite,
        aluSrc:   ctrl.aluSrc,
        regDst:   ctrl.regDst,
        aluOp:    ctrl.aluOp,
        rd1:      rd1,
        rd2:      rd2,
        signImm:  signImm,
        rs:       rs,
        rt:       rt,
        rd:       ifIdQ.instr[15:11]
    };

endmodule

`default_nettype wire

// File: design/fetchStage.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module fetchStage
    import mipsPkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  stallF,
    input  logic  redirect,     // taken beq or j in decode
    input  word_t target,
    output word_t pcF,
    output word_t pcPlus4
);

    word_t pcNext;

    assign pcPlus4 = pcF + 32'd4;
    assign pcNext  = redirect ? target : pcPlus4;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pcF <= `RESET_PC;
        end else if (!stallF) begin
            pcF <= pcNext;
        end
    end

endmodule

`default_nettype wire

// File: design/regFile.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module regFile
    import mipsPkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  regAddr_t ra1,
    input  regAddr_t ra2,
    output word_t    rd1,
    output word_t    rd2,
    input  logic     we,
    input  regAddr_t wa,
    input  word_t    wd
);

    word_t regs [2**`REG_ADDR_W];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 2**`REG_ADDR_W; i++) begin
                regs[i] <= '0;
            end
        end else if (we && wa != '0) begin    // r0 stays zero
            regs[wa] <= wd;
        end
    end

    // writeback value bypasses the array in the same cycle
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

`default_nettype wire

// File: design/controlDecoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "mips_defs.svh"

module controlDecoder
    import mipsPkg::*;
(
    input  word_t instr,
    output ctrl_t ctrl
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        ctrl = '0;
        case (opcode)
            `OP_RTYPE: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDst   = 1'b1;
                case (funct)
                    `FN_ADD: ctrl.aluOp = ALU_ADD;
                    `FN_SUB: ctrl.aluOp = ALU_SUB;
                    `FN_AND: ctrl.aluOp = ALU_AND;
                    `FN_OR:  ctrl.aluOp = ALU_OR;
                    `FN_SLT: ctrl.aluOp = ALU_SLT;
                    default: ctrl = '0;     // includes the all-zero nop
                endcase
            end
            `OP_LW: begin
                ctrl.regWrite = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_ADD;    // base + offset
            end
            `OP_SW: begin
                ctrl.memWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            `OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.aluOp  = ALU_SUB;
            end
            `OP_ADDI: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluSrc   = 1'b1;
                ctrl.aluOp    = ALU_ADD;
            end
            `OP_J: begin
                ctrl.jump = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/pipeStageReg.sv
`timescale 1ns/100ps
`default_nettype none

// stage register shared by all four pipeline boundaries
module pipeStageReg
    import mipsPkg::*;
#(
    parameter type T = word_t
) (
    input  logic clk,
    input  logic rst,
    input  logic en,
    input  logic clear,
    input  T     d,
    output T     q
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            q <= '0;
        end else if (clear) begin
            q <= '0;        // all-zero payload acts as a nop
        end else if (en) begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

// File: design/mipsPkg.sv
`default_nettype none

`include "mips_defs.svh"

package mipsPkg;

    typedef logic [`DATA_W-1:0]     word_t;
    typedef logic [`REG_ADDR_W-1:0] regAddr_t;

    // alu select codes
    typedef enum logic [2:0] {
        ALU_AND = 3'b000,
        ALU_OR  = 3'b001,
        ALU_ADD = 3'b010,
        ALU_SUB = 3'b110,
        ALU_SLT = 3'b111
    } aluOp_t;

    // execute operand source
    typedef enum logic [1:0] {
        FWD_REG = 2'b00,    // value read in decode
        FWD_WB  = 2'b01,    // writeback result
        FWD_MEM = 2'b10     // memory-stage alu result
    } fwdSel_t;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        logic   aluSrc;     // immediate as operand b
        logic   regDst;     // rd instead of rt
        logic   branch;
        logic   jump;
        aluOp_t aluOp;
    } ctrl_t;

    ////////////////////////////////////////////////////////////
    // stage payloads
    typedef struct packed {
        word_t instr;
        word_t pcPlus4;
    } ifId_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        logic     memWrite;
        logic     aluSrc;
        logic     regDst;
        aluOp_t   aluOp;
        word_t    rd1;
        word_t    rd2;
        word_t    signImm;
        regAddr_t rs;
        regAddr_t rt;
        regAddr_t rd;
    } idEx_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        logic     memWrite;
        word_t    aluOut;
        word_t    writeData;
        regAddr_t writeReg;
    } exMem_t;

    typedef struct packed {
        logic     regWrite;
        logic     memToReg;
        word_t    readData;
        word_t    aluOut;
        regAddr_t writeReg;
    } memWb_t;

endpackage

`default_nettype wire

// File: design/mips_defs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// datapath and register index widths
`define DATA_W      32
`define REG_ADDR_W  5

`define RESET_PC    32'h0000_0000   // first fetch address

////////////////////////////////////////////////////////////
// opcodes, instr[31:26]
`define OP_RTYPE    6'b000000
`define OP_LW       6'b100011
`define OP_SW       6'b101011
`define OP_BEQ      6'b000100
`define OP_ADDI     6'b001000
`define OP_J        6'b000010

////////////////////////////////////////////////////////////
// funct codes for R-type, instr[5:0]
`define FN_ADD      6'b100000
`define FN_SUB      6'b100010
`define FN_AND      6'b100100
`define FN_OR       6'b100101
`define FN_SLT      6'b101010

`endif
